// ==== vlog.f ====
+incdir+hw
hw/frame_pkg.sv
hw/fabric_pkg.sv
hw/lookup_scheduler.sv
hw/ingress_release.sv
hw/crossbar_channel.sv
hw/switch_fabric.sv
bench/switch_fabric_asserts.sv
bench/switch_fabric_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the switch fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f \
	--top-module switch_fabric_tb \
	-o sim_switch_fabric
status=$?
if [ $status -ne 0 ]; then
	echo "Build failed with status $status"
	exit 1
fi

./obj_dir/sim_switch_fabric > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^No errors$" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// ==== bench/switch_fabric_tb.sv ====
`timescale 1ns/1ps
`include "fabric_defines.svh"

module switch_fabric_tb;

	localparam int NP      = `SF_NUM_PORTS;
	localparam int TIMEOUT = 400;

	logic clk;
	logic rst_n;

	// DUT inputs
	fabric_pkg::port_vec_t                     frame_valid;
	frame_pkg::macaddr_t [NP-1:0]              frame_src_mac;
	frame_pkg::macaddr_t [NP-1:0]              frame_dst_mac;
	frame_pkg::vlan_t [NP-1:0]                 frame_vlan;
	fabric_pkg::port_vec_t                     fwd_valid;
	frame_pkg::data_word_t [NP-1:0]            fwd_data;
	frame_pkg::bytes_valid_t [NP-1:0]          fwd_bytes_valid;
	logic                                      mac_lookup_hit;
	fabric_pkg::port_t                         mac_lookup_dst_port;
	fabric_pkg::port_vec_t                     tx_ready;

	// DUT outputs
	fabric_pkg::port_vec_t                     fifo_fwd_en;
	fabric_pkg::port_vec_t                     fifo_pop;
	logic                                      mac_lookup_en;
	fabric_pkg::port_t                         mac_lookup_src_port;
	frame_pkg::macaddr_t                       mac_lookup_src_mac;
	frame_pkg::macaddr_t                       mac_lookup_dst_mac;
	frame_pkg::vlan_t                          mac_lookup_vlan;
	fabric_pkg::port_vec_t                     tx_valid;
	frame_pkg::data_word_t [NP-1:0]            tx_data;
	frame_pkg::bytes_valid_t [NP-1:0]          tx_bytes_valid;
	frame_pkg::vlan_t [NP-1:0]                 tx_vlan;

	// Frame store, one entry per loaded frame
	logic [63:0] wstore [0:255];
	logic [47:0] fr_src [0:31];
	logic [47:0] fr_dst [0:31];
	logic [11:0] fr_vlan [0:31];
	logic [3:0]  fr_last [0:31];
	int          fr_base [0:31];
	int          fr_len [0:31];
	int          nfr;
	int          nw;

	// Ingress FIFO model state, queue of frame ids per port
	int fq [NP][$];
	int st [NP];
	int sid [NP];
	int widx [NP];
	int pops [NP];
	int pop_snap [NP][NP];

	// MAC table model
	fabric_pkg::port_t mac_tbl [logic [47:0]];
	logic              s1_en;
	logic [47:0]       s1_mac;

	// Values seen at the falling edge
	fabric_pkg::port_vec_t fe;
	fabric_pkg::port_vec_t pp;
	logic                  lk_en;
	logic [47:0]           lk_mac;

	// Egress capture
	logic [63:0] rx_d [NP][$];
	logic [3:0]  rx_b [NP][$];
	logic [11:0] rx_v [NP][$];

	int errors;
	int nchecks;
	integer seed;

	switch_fabric DUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// FIFO, table and egress models
	//////////////////////////////

	always begin
		@(negedge clk);
		fe     = fifo_fwd_en;
		pp     = fifo_pop;
		lk_en  = mac_lookup_en;
		lk_mac = mac_lookup_dst_mac;
		// Request fields against the head frame of the requesting port
		check_lookup();
		for (int p = 0; p < NP; p++) begin
			if (tx_valid[p]) begin
				rx_d[p].push_back(tx_data[p]);
				rx_b[p].push_back(tx_bytes_valid[p]);
				rx_v[p].push_back(tx_vlan[p]);
			end
		end
		// Snapshot of egress counts at each pop
		for (int p = 0; p < NP; p++) begin
			if (pp[p]) begin
				pops[p]++;
				for (int q = 0; q < NP; q++)
					pop_snap[p][q] = rx_d[q].size();
			end
		end
		@(posedge clk);
		#1;
		// Reply to the request of the previous cycle, two cycles after it
		mac_lookup_hit      = s1_en && mac_tbl.exists(s1_mac);
		mac_lookup_dst_port = mac_lookup_hit ? mac_tbl[s1_mac] : '0;
		s1_en               = lk_en;
		s1_mac              = lk_mac;
		for (int p = 0; p < NP; p++) begin
			// Gap cycle done, stream from the first word
			if (st[p] == 1) begin
				st[p]   = 2;
				widx[p] = 0;
			end
			if (st[p] == 2) begin
				if (widx[p] < fr_len[sid[p]]) begin
					fwd_valid[p]       = 1'b1;
					fwd_data[p]        = wstore[fr_base[sid[p]] + widx[p]];
					fwd_bytes_valid[p] = (widx[p] == fr_len[sid[p]] - 1) ? fr_last[sid[p]] : '0;
					widx[p]++;
				end else begin
					fwd_valid[p]       = 1'b0;
					fwd_data[p]        = '0;
					fwd_bytes_valid[p] = '0;
					st[p]              = 0;
				end
			end else if (fe[p] && fq[p].size() > 0) begin
				st[p]  = 1;
				sid[p] = fq[p][0];
			end
			if (pp[p] && fq[p].size() > 0)
				void'(fq[p].pop_front());
			// Head of queue on the frame bus
			frame_valid[p] = fq[p].size() > 0;
			if (fq[p].size() > 0) begin
				frame_src_mac[p] = fr_src[fq[p][0]];
				frame_dst_mac[p] = fr_dst[fq[p][0]];
				frame_vlan[p]    = fr_vlan[fq[p][0]];
			end
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic check(input string msg, input logic [63:0] got, input logic [63:0] exp);
		nchecks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	// Lookup must carry the MACs and VLAN of the frame waiting at its source port
	task automatic check_lookup();
		int id;
		if (mac_lookup_en) begin
			if (fq[mac_lookup_src_port].size() == 0) begin
				errors++;
				$display("Lookup at %0d ns for port %0d, which has no frame waiting", $time,
					mac_lookup_src_port);
			end else begin
				id = fq[mac_lookup_src_port][0];
				check("lookup source MAC", 64'(mac_lookup_src_mac), 64'(fr_src[id]));
				check("lookup destination MAC", 64'(mac_lookup_dst_mac), 64'(fr_dst[id]));
				check("lookup VLAN", 64'(mac_lookup_vlan), 64'(fr_vlan[id]));
			end
		end
	endtask

	// Random payload, byte count only on the last word
	task automatic add_frame(input int p, input logic [47:0] src, input logic [47:0] dst,
			input logic [11:0] vlan, input int len, input logic [3:0] last, output int id);
		id          = nfr;
		fr_src[id]  = src;
		fr_dst[id]  = dst;
		fr_vlan[id] = vlan;
		fr_last[id] = last;
		fr_base[id] = nw;
		fr_len[id]  = len;
		for (int k = 0; k < len; k++) begin
			wstore[nw] = {32'($random(seed)), 32'($random(seed))};
			nw++;
		end
		nfr++;
		fq[p].push_back(id);
	endtask

	task automatic clear_rx();
		for (int p = 0; p < NP; p++) begin
			rx_d[p].delete();
			rx_b[p].delete();
			rx_v[p].delete();
		end
	endtask

	task automatic wait_words(input int p, input int n);
		int t;
		t = 0;
		while (rx_d[p].size() < n && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (rx_d[p].size() < n) begin
			errors++;
			$display("Timeout at %0d ns while waiting for %0d words on port %0d", $time, n, p);
		end
	endtask

	task automatic wait_pops(input int p, input int n);
		int t;
		t = 0;
		while (pops[p] < n && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (pops[p] < n) begin
			errors++;
			$display("Timeout at %0d ns while waiting for a pop on port %0d", $time, p);
		end
	endtask

	// Compare one received frame against the store, starting at word off
	task automatic expect_frame(input int p, input int id, input int off);
		logic [3:0] eb;
		if (rx_d[p].size() < off + fr_len[id]) begin
			errors++;
			$display("Port %0d holds too few words for frame %0d", p, id);
		end else begin
			for (int k = 0; k < fr_len[id]; k++) begin
				eb = (k == fr_len[id] - 1) ? fr_last[id] : 4'd0;
				check($sformatf("port %0d data word %0d", p, k), rx_d[p][off+k],
					wstore[fr_base[id]+k]);
				check($sformatf("port %0d bytes word %0d", p, k), 64'(rx_b[p][off+k]), 64'(eb));
				check($sformatf("port %0d vlan word %0d", p, k), 64'(rx_v[p][off+k]),
					64'(fr_vlan[id]));
			end
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_reset();
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			check("mac_lookup_en idle", 64'(mac_lookup_en), 64'd0);
			check("fifo_fwd_en idle", 64'(fifo_fwd_en), 64'd0);
			check("fifo_pop idle", 64'(fifo_pop), 64'd0);
			check("tx_valid idle", 64'(tx_valid), 64'd0);
		end
	endtask

	task automatic test_unicast();
		int id;
		int b0;
		clear_rx();
		b0 = pops[0];
		add_frame(0, 48'h0000_00aa_0000, 48'h0000_00aa_0002, 12'h005, 4, 4'd3, id);
		wait_words(2, 4);
		wait_pops(0, b0 + 1);
		repeat (20) @(negedge clk);
		expect_frame(2, id, 0);
		check("unicast port 2 words", 64'(rx_d[2].size()), 64'd4);
		check("unicast port 0 words", 64'(rx_d[0].size()), 64'd0);
		check("unicast port 1 words", 64'(rx_d[1].size()), 64'd0);
		check("unicast port 3 words", 64'(rx_d[3].size()), 64'd0);
		check("unicast pops port 0", 64'(pops[0]), 64'(b0 + 1));
	endtask

	task automatic test_broadcast();
		int id;
		int b1;
		clear_rx();
		b1 = pops[1];
		// Destination not in the table
		add_frame(1, 48'h0000_00aa_0001, 48'h0000_0bad_0bad, 12'h123, 3, 4'd8, id);
		wait_pops(1, b1 + 1);
		repeat (20) @(negedge clk);
		for (int p = 0; p < NP; p++) begin
			if (p != 1) begin
				expect_frame(p, id, 0);
				check($sformatf("broadcast port %0d words", p), 64'(rx_d[p].size()), 64'd3);
				check($sformatf("port %0d complete at pop", p), 64'(pop_snap[1][p]), 64'd3);
			end
		end
		check("broadcast source words", 64'(rx_d[1].size()), 64'd0);
		check("broadcast pops port 1", 64'(pops[1]), 64'(b1 + 1));
	endtask

	task automatic test_backpressure();
		int id;
		int b2;
		clear_rx();
		b2 = pops[2];
		@(posedge clk);
		#1;
		tx_ready[3] = 1'b0;
		add_frame(2, 48'h0000_00aa_0002, 48'h0000_00aa_0003, 12'h0e7, 5, 4'd1, id);
		repeat (40) @(negedge clk);
		check("held frame words", 64'(rx_d[3].size()), 64'd0);
		check("held frame pops", 64'(pops[2]), 64'(b2));
		@(posedge clk);
		#1;
		tx_ready[3] = 1'b1;
		wait_words(3, 5);
		wait_pops(2, b2 + 1);
		repeat (20) @(negedge clk);
		expect_frame(3, id, 0);
		check("released frame words", 64'(rx_d[3].size()), 64'd5);
		check("released frame pops", 64'(pops[2]), 64'(b2 + 1));
	endtask

	// Ports 0 and 1 both to port 3, port 2 to port 0 alongside
	task automatic test_contention();
		int ia;
		int ib;
		int ic;
		int b0;
		int b1;
		int b2;
		clear_rx();
		b0 = pops[0];
		b1 = pops[1];
		b2 = pops[2];
		add_frame(0, 48'h0000_00aa_0000, 48'h0000_00aa_0003, 12'h010, 3, 4'd6, ia);
		add_frame(1, 48'h0000_00aa_0001, 48'h0000_00aa_0003, 12'h011, 4, 4'd2, ib);
		add_frame(2, 48'h0000_00aa_0002, 48'h0000_00aa_0000, 12'h012, 2, 4'd7, ic);
		wait_words(3, 7);
		wait_words(0, 2);
		wait_pops(0, b0 + 1);
		wait_pops(1, b1 + 1);
		wait_pops(2, b2 + 1);
		repeat (20) @(negedge clk);
		// Either order, but each frame whole
		if (rx_d[3].size() > 0 && rx_d[3][0] === wstore[fr_base[ia]]) begin
			expect_frame(3, ia, 0);
			expect_frame(3, ib, 3);
		end else begin
			expect_frame(3, ib, 0);
			expect_frame(3, ia, 4);
		end
		expect_frame(0, ic, 0);
		check("contention port 3 words", 64'(rx_d[3].size()), 64'd7);
		check("parallel port 0 words", 64'(rx_d[0].size()), 64'd2);
		check("contention pops port 0", 64'(pops[0]), 64'(b0 + 1));
		check("contention pops port 1", 64'(pops[1]), 64'(b1 + 1));
		check("parallel pops port 2", 64'(pops[2]), 64'(b2 + 1));
	endtask

	//////////////////////////////
	// Sequence and report
	//////////////////////////////

	initial begin
		seed                = 32'h2f38_ff6e;
		errors              = 0;
		nchecks             = 0;
		nfr                 = 0;
		nw                  = 0;
		rst_n               = 1'b0;
		frame_valid         = '0;
		frame_src_mac       = '0;
		frame_dst_mac       = '0;
		frame_vlan          = '0;
		fwd_valid           = '0;
		fwd_data            = '0;
		fwd_bytes_valid     = '0;
		mac_lookup_hit      = 1'b0;
		mac_lookup_dst_port = '0;
		tx_ready            = '1;
		s1_en               = 1'b0;
		s1_mac              = '0;
		for (int p = 0; p < NP; p++) begin
			st[p]   = 0;
			sid[p]  = 0;
			widx[p] = 0;
			pops[p] = 0;
			// Station behind each port
			mac_tbl[48'h0000_00aa_0000 + 48'(p)] = fabric_pkg::port_t'(p);
		end
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_unicast();
		test_broadcast();
		test_backpressure();
		test_contention();
		repeat (10) @(posedge clk);
		$display("Checks run: %0d, errors: %0d", nchecks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Hard limit on the whole run
	initial begin
		#1_000_000;
		$display("Simulation did not finish within its time limit");
		$display("Errors found");
		$finish;
	end

endmodule

// ==== bench/switch_fabric_asserts.sv ====
`timescale 1ns/1ps
`include "fabric_defines.svh"

module switch_fabric_asserts (
	input logic                  clk,
	input logic                  rst_n,
	input fabric_pkg::port_vec_t tx_valid,
	input fabric_pkg::port_vec_t fifo_pop,
	input fabric_pkg::port_vec_t fifo_fwd_en,
	input logic                  mac_lookup_en,
	input fabric_pkg::port_t     mac_lookup_src_port,
	input fabric_pkg::port_vec_t dst_valid
);

	// Outputs quiet while held in reset
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |=> (tx_valid == '0 && fifo_pop == '0))
		else $error("tx_valid or fifo_pop active during reset");

	// Reply stored for the requesting port, visible one edge after the store
	a_lookup_stored: assert property (@(posedge clk) disable iff (!rst_n)
		mac_lookup_en |-> ##3 dst_valid[$past(mac_lookup_src_port, 3)])
		else $error("lookup reply not stored for its port");

	// Single-cycle pops
	a_pop_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		|fifo_pop |=> (fifo_pop & $past(fifo_pop)) == '0)
		else $error("fifo_pop high two cycles in a row");

	// No forward request to a FIFO that is dropping its head
	a_fwd_vs_pop: assert property (@(posedge clk) disable iff (!rst_n)
		(fifo_fwd_en & fifo_pop) == '0)
		else $error("fifo_fwd_en and fifo_pop together");

endmodule

bind switch_fabric switch_fabric_asserts u_asserts (
	.clk                 (clk),
	.rst_n               (rst_n),
	.tx_valid            (tx_valid),
	.fifo_pop            (fifo_pop),
	.fifo_fwd_en         (fifo_fwd_en),
	.mac_lookup_en       (mac_lookup_en),
	.mac_lookup_src_port (mac_lookup_src_port),
	.dst_valid           (dst_valid)
);

// ==== hw/switch_fabric.sv ====
`timescale 1ns/1ps
`include "fabric_defines.svh"

module switch_fabric (
	input  logic                                          clk,
	input  logic                                          rst_n,
	// Ingress FIFOs
	input  fabric_pkg::port_vec_t                         frame_valid,
	input  frame_pkg::macaddr_t [`SF_NUM_PORTS-1:0]       frame_src_mac,
	input  frame_pkg::macaddr_t [`SF_NUM_PORTS-1:0]       frame_dst_mac,
	input  frame_pkg::vlan_t [`SF_NUM_PORTS-1:0]          frame_vlan,
	input  fabric_pkg::port_vec_t                         fwd_valid,
	input  frame_pkg::data_word_t [`SF_NUM_PORTS-1:0]     fwd_data,
	input  frame_pkg::bytes_valid_t [`SF_NUM_PORTS-1:0]   fwd_bytes_valid,
	output fabric_pkg::port_vec_t                         fifo_fwd_en,
	output fabric_pkg::port_vec_t                         fifo_pop,
	// MAC table
	output logic                                          mac_lookup_en,
	output fabric_pkg::port_t                             mac_lookup_src_port,
	output frame_pkg::macaddr_t                           mac_lookup_src_mac,
	output frame_pkg::macaddr_t                           mac_lookup_dst_mac,
	output frame_pkg::vlan_t                              mac_lookup_vlan,
	input  logic                                          mac_lookup_hit,
	input  fabric_pkg::port_t                             mac_lookup_dst_port,
	// Egress FIFOs
	input  fabric_pkg::port_vec_t                         tx_ready,
	output fabric_pkg::port_vec_t                         tx_valid,
	output frame_pkg::data_word_t [`SF_NUM_PORTS-1:0]     tx_data,
	output frame_pkg::bytes_valid_t [`SF_NUM_PORTS-1:0]   tx_bytes_valid,
	output frame_pkg::vlan_t [`SF_NUM_PORTS-1:0]          tx_vlan
);

	// Destination state per ingress port
	fabric_pkg::port_vec_t                     dst_valid;
	fabric_pkg::port_vec_t                     dst_broadcast;
	fabric_pkg::port_t [`SF_NUM_PORTS-1:0]     dst_port;

	// Release bookkeeping
	fabric_pkg::port_vec_t                     forwarding;
	fabric_pkg::port_vec_t [`SF_NUM_PORTS-1:0] bcast_done;

	// Channel status, index is the egress port
	fabric_pkg::port_vec_t                     chan_start;
	fabric_pkg::port_vec_t                     chan_done;
	fabric_pkg::port_t [`SF_NUM_PORTS-1:0]     chan_src;
	fabric_pkg::port_vec_t [`SF_NUM_PORTS-1:0] chan_fwd_en;

	lookup_scheduler u_lookup (
		.clk                 (clk),
		.rst_n               (rst_n),
		.frame_valid         (frame_valid),
		.frame_src_mac       (frame_src_mac),
		.frame_dst_mac       (frame_dst_mac),
		.frame_vlan          (frame_vlan),
		.fifo_pop            (fifo_pop),
		.mac_lookup_en       (mac_lookup_en),
		.mac_lookup_src_port (mac_lookup_src_port),
		.mac_lookup_src_mac  (mac_lookup_src_mac),
		.mac_lookup_dst_mac  (mac_lookup_dst_mac),
		.mac_lookup_vlan     (mac_lookup_vlan),
		.mac_lookup_hit      (mac_lookup_hit),
		.mac_lookup_dst_port (mac_lookup_dst_port),
		.dst_valid           (dst_valid),
		.dst_broadcast       (dst_broadcast),
		.dst_port            (dst_port)
	);

	ingress_release u_release (
		.clk           (clk),
		.rst_n         (rst_n),
		.dst_valid     (dst_valid),
		.dst_broadcast (dst_broadcast),
		.chan_start    (chan_start),
		.chan_done     (chan_done),
		.chan_src      (chan_src),
		.forwarding    (forwarding),
		.bcast_done    (bcast_done),
		.fifo_pop      (fifo_pop)
	);

	//////////////////////////////
	// Crossbar channels
	//////////////////////////////

	for (genvar c = 0; c < `SF_NUM_PORTS; c++) begin : g_chan
		crossbar_channel #(
			.CHAN_PORT (c)
		) u_chan (
			.clk             (clk),
			.rst_n           (rst_n),
			.tx_ready        (tx_ready[c]),
			.dst_valid       (dst_valid),
			.dst_broadcast   (dst_broadcast),
			.forwarding      (forwarding),
			.fifo_pop        (fifo_pop),
			.dst_port        (dst_port),
			.bcast_done      (bcast_done),
			.fwd_valid       (fwd_valid),
			.fifo_fwd_en     (fifo_fwd_en),
			.fwd_data        (fwd_data),
			.fwd_bytes_valid (fwd_bytes_valid),
			.frame_vlan      (frame_vlan),
			.chan_start      (chan_start[c]),
			.chan_done       (chan_done[c]),
			.chan_src        (chan_src[c]),
			.chan_fwd_en     (chan_fwd_en[c]),
			.tx_valid        (tx_valid[c]),
			.tx_data         (tx_data[c]),
			.tx_bytes_valid  (tx_bytes_valid[c]),
			.tx_vlan         (tx_vlan[c])
		);
	end

	// Broadcast channels granted together share one request
	always_comb begin
		fifo_fwd_en = '0;
		for (int c = 0; c < `SF_NUM_PORTS; c++)
			fifo_fwd_en = fifo_fwd_en | chan_fwd_en[c];
	end

endmodule

// ==== hw/crossbar_channel.sv ====
`timescale 1ns/1ps
`include "fabric_defines.svh"

module crossbar_channel #(
	// Egress port served by this channel
	parameter int CHAN_PORT = 0
) (
	input  logic                                          clk,
	input  logic                                          rst_n,
	// Egress FIFO has room for a whole frame
	input  logic                                          tx_ready,
	// Source state
	input  fabric_pkg::port_vec_t                         dst_valid,
	input  fabric_pkg::port_vec_t                         dst_broadcast,
	input  fabric_pkg::port_vec_t                         forwarding,
	input  fabric_pkg::port_vec_t                         fifo_pop,
	input  fabric_pkg::port_t [`SF_NUM_PORTS-1:0]         dst_port,
	input  fabric_pkg::port_vec_t [`SF_NUM_PORTS-1:0]     bcast_done,
	// Ingress FIFO read side
	input  fabric_pkg::port_vec_t                         fwd_valid,
	input  fabric_pkg::port_vec_t                         fifo_fwd_en,
	input  frame_pkg::data_word_t [`SF_NUM_PORTS-1:0]     fwd_data,
	input  frame_pkg::bytes_valid_t [`SF_NUM_PORTS-1:0]   fwd_bytes_valid,
	input  frame_pkg::vlan_t [`SF_NUM_PORTS-1:0]          frame_vlan,
	// Channel status
	output logic                                          chan_start,
	output logic                                          chan_done,
	output fabric_pkg::port_t                             chan_src,
	output fabric_pkg::port_vec_t                         chan_fwd_en,
	// Egress FIFO write side
	output logic                                          tx_valid,
	output frame_pkg::data_word_t                         tx_data,
	output frame_pkg::bytes_valid_t                       tx_bytes_valid,
	output frame_pkg::vlan_t                              tx_vlan
);

	localparam fabric_pkg::port_t MY_PORT = fabric_pkg::port_t'(CHAN_PORT);

	fabric_pkg::chan_state_t state;

	// Arbitration
	fabric_pkg::port_t     rr_src;
	fabric_pkg::port_t     sel_src;
	fabric_pkg::port_vec_t eligible;
	logic                  hit;
	logic                  grant;

	// Source being copied and its frame VLAN
	fabric_pkg::port_t src_q;
	frame_pkg::vlan_t  vlan_q;

	// Combined forward enables of the last two cycles
	fabric_pkg::port_vec_t fwd_en_d1;
	fabric_pkg::port_vec_t fwd_en_d2;
	logic                  xfer_end;

	// Mux output register
	logic                    pipe_valid;
	frame_pkg::data_word_t   pipe_data;
	frame_pkg::bytes_valid_t pipe_bytes;

	//////////////////////////////
	// Source selection
	//////////////////////////////

	// Who wants this port and is free to send
	always_comb begin
		for (int s = 0; s < `SF_NUM_PORTS; s++) begin
			if (!dst_valid[s] || fifo_pop[s] || forwarding[s])
				eligible[s] = 1'b0;
			// Flood to everyone but the source, once per port
			else if (dst_broadcast[s])
				eligible[s] = (s != CHAN_PORT) && !bcast_done[s][CHAN_PORT];
			else
				eligible[s] = (dst_port[s] == MY_PORT);
		end
	end

	// First eligible source at or after the round-robin offset
	always_comb begin
		int idx;
		hit     = 1'b0;
		sel_src = rr_src;
		for (int i = 0; i < `SF_NUM_PORTS; i++) begin
			idx = int'(rr_src) + i;
			if (idx >= `SF_NUM_PORTS)
				idx = idx - `SF_NUM_PORTS;
			if (!hit && eligible[idx]) begin
				hit     = 1'b1;
				sel_src = fabric_pkg::port_t'(idx);
			end
		end
	end

	// No new frame while the egress FIFO is short of room
	assign grant      = (state == fabric_pkg::CHAN_IDLE) && tx_ready && hit;
	assign chan_start = grant;
	assign chan_src   = grant ? sel_src : src_q;

	// Forward request goes out during the start cycle
	assign chan_fwd_en = (state == fabric_pkg::CHAN_START) ?
		(fabric_pkg::port_vec_t'(1) << src_q) : '0;

	// End of run: no word now and no request still pending
	assign xfer_end  = !fwd_valid[src_q] && !fwd_en_d1[src_q] && !fwd_en_d2[src_q];
	assign chan_done = (state == fabric_pkg::CHAN_BUSY) && xfer_end;

	//////////////////////////////
	// Channel FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= fabric_pkg::CHAN_IDLE;
			rr_src    <= '0;
			fwd_en_d1 <= '0;
			fwd_en_d2 <= '0;
		end else begin
			fwd_en_d1 <= fifo_fwd_en;
			fwd_en_d2 <= fwd_en_d1;
			case (state)
				fabric_pkg::CHAN_IDLE:
					if (grant)
						state <= fabric_pkg::CHAN_START;
				fabric_pkg::CHAN_START:
					state <= fabric_pkg::CHAN_BUSY;
				fabric_pkg::CHAN_BUSY:
					if (xfer_end) begin
						state <= fabric_pkg::CHAN_IDLE;
						// Next scan begins one source further on
						if (rr_src == fabric_pkg::port_t'(`SF_NUM_PORTS - 1))
							rr_src <= '0;
						else
							rr_src <= rr_src + 1'b1;
					end
				default:
					state <= fabric_pkg::CHAN_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (grant)
			src_q <= sel_src;
		if (state == fabric_pkg::CHAN_START)
			vlan_q <= frame_vlan[src_q];
	end

	//////////////////////////////
	// Data path
	//////////////////////////////

	// Crossbar mux, one register stage
	always_ff @(posedge clk) begin
		if (!rst_n)
			pipe_valid <= 1'b0;
		else
			pipe_valid <= (state == fabric_pkg::CHAN_BUSY) && fwd_valid[src_q];
	end

	always_ff @(posedge clk) begin
		pipe_data  <= fwd_data[src_q];
		pipe_bytes <= fwd_bytes_valid[src_q];
	end

	// Egress register, zeroed between words
	always_ff @(posedge clk) begin
		if (!rst_n)
			tx_valid <= 1'b0;
		else
			tx_valid <= pipe_valid;
	end

	always_ff @(posedge clk) begin
		tx_data        <= pipe_valid ? pipe_data : '0;
		tx_bytes_valid <= pipe_valid ? pipe_bytes : '0;
		tx_vlan        <= pipe_valid ? vlan_q : '0;
	end

endmodule

// ==== hw/ingress_release.sv ====
`timescale 1ns/1ps
`include "fabric_defines.svh"

module ingress_release (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  fabric_pkg::port_vec_t                       dst_valid,
	input  fabric_pkg::port_vec_t                       dst_broadcast,
	// One bit per crossbar channel
	input  fabric_pkg::port_vec_t                       chan_start,
	input  fabric_pkg::port_vec_t                       chan_done,
	input  fabric_pkg::port_t [`SF_NUM_PORTS-1:0]       chan_src,
	output fabric_pkg::port_vec_t                       forwarding,
	// Per source, which egress ports already got the broadcast
	output fabric_pkg::port_vec_t [`SF_NUM_PORTS-1:0]   bcast_done,
	output fabric_pkg::port_vec_t                       fifo_pop
);

	// Channels reading from each source, indexed [src][chan]
	fabric_pkg::port_vec_t [`SF_NUM_PORTS-1:0] active;

	// Unicast transfer finished this cycle, per source
	fabric_pkg::port_vec_t unicast_end;

	//////////////////////////////
	// Forwarding flags
	//////////////////////////////

	// Several channels may share one broadcast source
	// Flag stays up until the last of them is done
	always_comb begin
		for (int s = 0; s < `SF_NUM_PORTS; s++)
			forwarding[s] = |active[s];
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			active <= '0;
		else begin
			for (int c = 0; c < `SF_NUM_PORTS; c++) begin
				if (chan_start[c])
					active[chan_src[c]][c] <= 1'b1;
				else if (chan_done[c])
					active[chan_src[c]][c] <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Broadcast completion
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n)
			bcast_done <= '0;
		else begin
			for (int s = 0; s < `SF_NUM_PORTS; s++) begin
				if (fifo_pop[s])
					bcast_done[s] <= '0;
				// Never sent back to its own port, so count it as delivered
				bcast_done[s][s] <= 1'b1;
			end
			// Egress port index equals channel index
			for (int c = 0; c < `SF_NUM_PORTS; c++)
				if (chan_done[c] && dst_broadcast[chan_src[c]] && !fifo_pop[chan_src[c]])
					bcast_done[chan_src[c]][c] <= 1'b1;
		end
	end

	//////////////////////////////
	// FIFO pop
	//////////////////////////////

	always_comb begin
		unicast_end = '0;
		for (int s = 0; s < `SF_NUM_PORTS; s++)
			for (int c = 0; c < `SF_NUM_PORTS; c++)
				if (chan_done[c] && chan_src[c] == fabric_pkg::port_t'(s) && !dst_broadcast[s])
					unicast_end[s] = 1'b1;
	end

	// Unicast right after its one transfer, broadcast once every port has it
	always_ff @(posedge clk) begin
		if (!rst_n)
			fifo_pop <= '0;
		else begin
			for (int s = 0; s < `SF_NUM_PORTS; s++)
				fifo_pop[s] <= unicast_end[s] ||
					(dst_valid[s] && dst_broadcast[s] && !fifo_pop[s] && &bcast_done[s]);
		end
	end

endmodule

// ==== hw/lookup_scheduler.sv ====
`timescale 1ns/1ps
`include "fabric_defines.svh"

module lookup_scheduler (
	input  logic clk,
	input  logic rst_n,
	// Ingress FIFO heads
	input  fabric_pkg::port_vec_t                      frame_valid,
	input  frame_pkg::macaddr_t [`SF_NUM_PORTS-1:0]    frame_src_mac,
	input  frame_pkg::macaddr_t [`SF_NUM_PORTS-1:0]    frame_dst_mac,
	input  frame_pkg::vlan_t [`SF_NUM_PORTS-1:0]       frame_vlan,
	input  fabric_pkg::port_vec_t                      fifo_pop,
	// MAC table request and reply
	output logic                                       mac_lookup_en,
	output fabric_pkg::port_t                          mac_lookup_src_port,
	output frame_pkg::macaddr_t                        mac_lookup_src_mac,
	output frame_pkg::macaddr_t                        mac_lookup_dst_mac,
	output frame_pkg::vlan_t                           mac_lookup_vlan,
	input  logic                                       mac_lookup_hit,
	input  fabric_pkg::port_t                          mac_lookup_dst_port,
	// Per-port destination state
	output fabric_pkg::port_vec_t                      dst_valid,
	output fabric_pkg::port_vec_t                      dst_broadcast,
	output fabric_pkg::port_t [`SF_NUM_PORTS-1:0]      dst_port
);

	// Port offered a lookup this cycle
	fabric_pkg::port_t rr_port;

	// Request tracking so each reply finds its source port
	logic [`SF_LOOKUP_LATENCY-1:0]                    en_pipe;
	fabric_pkg::port_t [`SF_LOOKUP_LATENCY-1:0]       port_pipe;

	logic issue;

	// Head frame present, destination unknown, not on its way out
	assign issue = frame_valid[rr_port] && !dst_valid[rr_port] && !fifo_pop[rr_port];

	//////////////////////////////
	// Request side
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr_port       <= '0;
			mac_lookup_en <= 1'b0;
		end else begin
			// One port per cycle, wrap at the last port
			if (rr_port == fabric_pkg::port_t'(`SF_NUM_PORTS - 1))
				rr_port <= '0;
			else
				rr_port <= rr_port + 1'b1;
			mac_lookup_en <= issue;
		end
	end

	// Request fields are only looked at while mac_lookup_en is high
	always_ff @(posedge clk) begin
		if (issue) begin
			mac_lookup_src_port <= rr_port;
			mac_lookup_src_mac  <= frame_src_mac[rr_port];
			mac_lookup_dst_mac  <= frame_dst_mac[rr_port];
			mac_lookup_vlan     <= frame_vlan[rr_port];
		end
	end

	//////////////////////////////
	// Reply side
	//////////////////////////////

	// Delay line of enable and source port, one stage per cycle of table latency
	always_ff @(posedge clk) begin
		if (!rst_n)
			en_pipe <= '0;
		else begin
			en_pipe[0] <= mac_lookup_en;
			for (int i = 1; i < `SF_LOOKUP_LATENCY; i++)
				en_pipe[i] <= en_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		port_pipe[0] <= mac_lookup_src_port;
		for (int i = 1; i < `SF_LOOKUP_LATENCY; i++)
			port_pipe[i] <= port_pipe[i-1];
	end

	// Store reply; a miss floods the frame
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dst_valid     <= '0;
			dst_broadcast <= '0;
		end else begin
			if (en_pipe[`SF_LOOKUP_LATENCY-1]) begin
				dst_valid[port_pipe[`SF_LOOKUP_LATENCY-1]]     <= 1'b1;
				dst_broadcast[port_pipe[`SF_LOOKUP_LATENCY-1]] <= !mac_lookup_hit;
			end
			// Popped frame needs a fresh lookup for the next one
			for (int p = 0; p < `SF_NUM_PORTS; p++)
				if (fifo_pop[p])
					dst_valid[p] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (en_pipe[`SF_LOOKUP_LATENCY-1])
			dst_port[port_pipe[`SF_LOOKUP_LATENCY-1]] <= mac_lookup_dst_port;
	end

endmodule

// ==== hw/fabric_pkg.sv ====
`include "fabric_defines.svh"

package fabric_pkg;

	//////////////////////////////
	// Fabric bookkeeping
	//////////////////////////////

	// Ingress or egress port number
	typedef logic [`SF_PORT_BITS-1:0] port_t;

	// One flag per fabric port
	typedef logic [`SF_NUM_PORTS-1:0] port_vec_t;

	// Crossbar channel FSM
	// Idle scans sources, start requests the forward, busy copies words
	typedef enum logic [1:0] {
		CHAN_IDLE  = 2'd0,
		CHAN_START = 2'd1,
		CHAN_BUSY  = 2'd2
	} chan_state_t;

endpackage

// ==== hw/frame_pkg.sv ====
`include "fabric_defines.svh"

package frame_pkg;

	//////////////////////////////
	// Frame contents
	//////////////////////////////

	// Ethernet MAC address
	typedef logic [47:0] macaddr_t;

	// 802.1Q VLAN id
	typedef logic [11:0] vlan_t;

	// One word of frame data on the fabric
	typedef logic [`SF_DATA_BITS-1:0] data_word_t;

	// Valid bytes in the last word, 0 means a full word
	typedef logic [`SF_BYTES_BITS-1:0] bytes_valid_t;

endpackage

// ==== hw/fabric_defines.svh ====
`ifndef FABRIC_DEFINES_SVH
`define FABRIC_DEFINES_SVH

//////////////////////////////
// Fabric geometry
//////////////////////////////

// Number of fabric ports, one crossbar channel each
`define SF_NUM_PORTS 4

// Width of a port id
`define SF_PORT_BITS 2

// Fabric data word
`define SF_DATA_BITS 64

// Valid byte count of the last word
`define SF_BYTES_BITS 4

// Cycles from lookup request to MAC table reply
`define SF_LOOKUP_LATENCY 2

`endif
